//--- all.f
+incdir+verilog
verilog/packet_pkg.sv
verilog/packet_mem.sv
verilog/packet_enqueue.sv
verilog/packet_write.sv
verilog/packet_buffer_top.sv
tests/packet_buffer_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the packet buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module packet_buffer_tb \
    -f all.f -o packet_buffer_sim

output=$(./obj_dir/packet_buffer_sim)
echo "$output"

if grep -qxF "** PASS **" <<< "$output"; then
    exit 0
fi
exit 1

//--- tests/packet_buffer_tb.sv
// ----------------------------------------
// Packet buffer testbench with random packets
// checked against a pointer and data model
// ----------------------------------------
`include "packet_params.svh"

module packet_buffer_tb
    import packet_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 10;
    localparam int NUM_PKTS       = 300;
    localparam int REGION_WORDS   = 2 ** `PKT_ADDR_WID;
    localparam int INIT_CYCLES    = 2 * REGION_WORDS * `PKT_NUM_CTXT + 20;
    localparam int EVT_WAIT       = 8;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * 40 + INIT_CYCLES;

    logic                     clk;
    logic                     srst;
    logic                     in_valid;
    logic [`PKT_DATA_WID-1:0] in_data;
    logic                     in_eop;
    mty_t                     in_mty;
    logic                     in_err;
    ctxt_t                    ctxt_sel;
    logic                     in_ready;
    logic                     wr_desc_valid;
    ctxt_t                    wr_desc_ctxt;
    addr_t                    wr_desc_addr;
    size_t                    wr_desc_size;
    logic                     rd_desc_valid;
    ctxt_t                    rd_desc_ctxt;
    size_t                    rd_desc_size;
    logic                     evt_valid;
    event_kind_t              evt_kind;
    size_t                    evt_size;
    logic                     rd_en;
    ctxt_t                    rd_ctxt;
    addr_t                    rd_addr;
    logic [`PKT_DATA_WID-1:0] rd_data;
    logic                     mem_init_done;

    int errors     = 0;
    int evt_count  = 0;
    int desc_count = 0;
    int ok_count   = 0;
    int wraps      = 0;

    // Head pointer per context and words of the packet in flight
    int                       head [`PKT_NUM_CTXT];
    logic [`PKT_DATA_WID-1:0] pkt_words [$];

    packet_buffer_top UUT (
        .clk           (clk),
        .srst          (srst),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_eop        (in_eop),
        .in_mty        (in_mty),
        .in_err        (in_err),
        .ctxt_sel      (ctxt_sel),
        .in_ready      (in_ready),
        .wr_desc_valid (wr_desc_valid),
        .wr_desc_ctxt  (wr_desc_ctxt),
        .wr_desc_addr  (wr_desc_addr),
        .wr_desc_size  (wr_desc_size),
        .rd_desc_valid (rd_desc_valid),
        .rd_desc_ctxt  (rd_desc_ctxt),
        .rd_desc_size  (rd_desc_size),
        .evt_valid     (evt_valid),
        .evt_kind      (evt_kind),
        .evt_size      (evt_size),
        .rd_en         (rd_en),
        .rd_ctxt       (rd_ctxt),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .mem_init_done (mem_init_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Strobe counts for the one-per-packet check at the end
    always @(negedge clk) begin
        if (!srst && evt_valid) begin
            evt_count++;
        end
        if (!srst && wr_desc_valid) begin
            desc_count++;
        end
    end

    task automatic log_failure(input string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    // Hold a word until taken; returns at the negedge after the transfer
    task automatic send_word(input logic [`PKT_DATA_WID-1:0] data, input logic eop,
                             input mty_t mty, input logic err, input ctxt_t ctxt);
        logic taken;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_data  = data;
        in_eop   = eop;
        in_mty   = mty;
        in_err   = err;
        ctxt_sel = ctxt;
        while (!taken) begin
            taken = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_eop   = 1'b0;
        in_err   = 1'b0;
    endtask

    task automatic read_word(input ctxt_t ctxt, input addr_t addr,
                             output logic [`PKT_DATA_WID-1:0] data);
        rd_en   = 1'b1;
        rd_ctxt = ctxt;
        rd_addr = addr;
        @(negedge clk);
        data  = rd_data;
        rd_en = 1'b0;
    endtask

    // ----------------------------------------
    // Main stimulus
    // ----------------------------------------
    initial begin
        int                       wait_cycles;
        int                       n_words;
        int                       err_word;
        int                       pkt_size;
        ctxt_t                    ctxt;
        mty_t                     mty;
        addr_t                    desc_addr;
        event_kind_t              exp_kind;
        logic [`PKT_DATA_WID-1:0] word;

        void'($urandom(32'hb0f5));
        srst          = 1'b1;
        in_valid      = 1'b0;
        in_data       = '0;
        in_eop        = 1'b0;
        in_mty        = '0;
        in_err        = 1'b0;
        ctxt_sel      = '0;
        rd_desc_valid = 1'b0;
        rd_desc_ctxt  = '0;
        rd_desc_size  = '0;
        rd_en         = 1'b0;
        rd_ctxt       = '0;
        rd_addr       = '0;
        for (int c = 0; c < `PKT_NUM_CTXT; c++) begin
            head[c] = 0;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        srst = 1'b0;

        // No ready until init is done, then every word reads zero
        wait_cycles = 0;
        while (!mem_init_done && wait_cycles < INIT_CYCLES) begin
            if (in_ready) begin
                log_failure("in_ready high before mem_init_done");
            end
            @(negedge clk);
            wait_cycles++;
        end
        if (!mem_init_done) begin
            errors++;
            $display("ERROR at %0t ns: memory init never finished", $time);
        end
        for (int c = 0; c < `PKT_NUM_CTXT; c++) begin
            for (int a = 0; a < REGION_WORDS; a++) begin
                read_word(ctxt_t'(c), addr_t'(a), word);
                if (word !== '0) begin
                    log_failure($sformatf("ctxt %0d addr %0d reads %h after init", c, a, word));
                end
            end
        end

        for (int p = 0; p < NUM_PKTS; p++) begin
            ctxt     = ctxt_t'($urandom % `PKT_NUM_CTXT);
            n_words  = 1 + int'($urandom % 20);
            mty      = mty_t'($urandom % 4);
            err_word = ($urandom % 10 == 0) ? int'($urandom % n_words) : -1;
            pkt_words.delete();
            for (int w = 0; w < n_words; w++) begin
                word = $urandom;
                pkt_words.push_back(word);
                send_word(word, w == n_words - 1, mty, w == err_word, ctxt);
                // Idle gaps only inside the packet
                if (w < n_words - 1 && $urandom % 4 == 0) begin
                    repeat (1 + $urandom % 2) @(negedge clk);
                end
            end

            pkt_size = n_words * `PKT_DATA_BYTES - int'(mty);
            if (err_word >= 0) begin
                exp_kind = EVT_DROP_ERR;
            end else if (pkt_size > `PKT_MAX_BYTES) begin
                exp_kind = EVT_DROP_LONG;
            end else if (pkt_size < `PKT_MIN_BYTES) begin
                exp_kind = EVT_DROP_SHORT;
            end else begin
                exp_kind = EVT_OK;
            end

            wait_cycles = 0;
            while (!evt_valid && wait_cycles < EVT_WAIT) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (!evt_valid) begin
                errors++;
                $display("ERROR at %0t ns: no event for packet %0d", $time, p);
            end else begin
                if (evt_kind != exp_kind) begin
                    log_failure($sformatf("pkt %0d event kind %0d, expected %0d",
                                          p, evt_kind, exp_kind));
                end
                if (exp_kind != EVT_OK && wr_desc_valid) begin
                    log_failure($sformatf("pkt %0d dropped but got a descriptor", p));
                end
                if (exp_kind == EVT_OK && !wr_desc_valid) begin
                    log_failure($sformatf("pkt %0d clean but no descriptor", p));
                end
                if (exp_kind == EVT_OK && wr_desc_valid) begin
                    desc_addr = wr_desc_addr;
                    if (wr_desc_ctxt != ctxt || desc_addr != addr_t'(head[ctxt]) ||
                        wr_desc_size != size_t'(pkt_size)) begin
                        log_failure($sformatf("pkt %0d desc ctxt %0d addr %0d size %0d, %s",
                                    p, wr_desc_ctxt, desc_addr, wr_desc_size,
                                    $sformatf("expected %0d %0d %0d",
                                              ctxt, head[ctxt], pkt_size)));
                    end
                    if (evt_size != size_t'(pkt_size)) begin
                        log_failure($sformatf("pkt %0d event size %0d, expected %0d",
                                              p, evt_size, pkt_size));
                    end
                    // Read back with wrap inside the region
                    for (int w = 0; w < n_words; w++) begin
                        read_word(ctxt, desc_addr + addr_t'(w), word);
                        if (word !== pkt_words[w]) begin
                            log_failure($sformatf("pkt %0d word %0d reads %h, expected %h",
                                                  p, w, word, pkt_words[w]));
                        end
                    end
                    // Hand the space back before the next packet
                    rd_desc_valid = 1'b1;
                    rd_desc_ctxt  = ctxt;
                    rd_desc_size  = size_t'(pkt_size);
                    @(negedge clk);
                    rd_desc_valid = 1'b0;
                end
            end

            if (exp_kind == EVT_OK) begin
                ok_count++;
                if (head[ctxt] + n_words >= REGION_WORDS) begin
                    wraps++;
                end
                head[ctxt] = (head[ctxt] + n_words) % REGION_WORDS;
            end
        end

        repeat (4) @(negedge clk);
        if (evt_count != NUM_PKTS) begin
            errors++;
            $display("ERROR: saw %0d events for %0d packets", evt_count, NUM_PKTS);
        end
        if (desc_count != ok_count) begin
            errors++;
            $display("ERROR: saw %0d descriptors for %0d clean packets", desc_count, ok_count);
        end
        if (wraps == 0) begin
            errors++;
            $display("ERROR: no head pointer wrapped around its region");
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        errors++;
        $display("ERROR at %0t ns: watchdog timeout, the run did not finish", $time);
        $display("Errors: %0d", errors);
        $display("** FAIL **");
        $finish;
    end

endmodule : packet_buffer_tb

//--- verilog/packet_buffer_top.sv
// ----------------------------------------
// Packet buffer front end top level
// ----------------------------------------
`include "packet_params.svh"

module packet_buffer_top
    import packet_pkg::*;
(
    input  logic                     clk,
    input  logic                     srst,

    // Input stream
    input  logic                     in_valid,
    input  logic [`PKT_DATA_WID-1:0] in_data,
    input  logic                     in_eop,
    input  mty_t                     in_mty,
    input  logic                     in_err,
    input  ctxt_t                    ctxt_sel,
    output logic                     in_ready,

    // Write descriptor
    output logic                     wr_desc_valid,
    output ctxt_t                    wr_desc_ctxt,
    output addr_t                    wr_desc_addr,
    output size_t                    wr_desc_size,

    // Read completion
    input  logic                     rd_desc_valid,
    input  ctxt_t                    rd_desc_ctxt,
    input  size_t                    rd_desc_size,

    // Packet events
    output logic                     evt_valid,
    output event_kind_t              evt_kind,
    output size_t                    evt_size,

    // Memory read port and init status
    input  logic                     rd_en,
    input  ctxt_t                    rd_ctxt,
    input  addr_t                    rd_addr,
    output logic [`PKT_DATA_WID-1:0] rd_data,
    output logic                     mem_init_done
);

    ctxt_t                    wr_ctxt;
    addr_t                    nxt_addr;
    size_t                    nxt_headroom;

    logic                     commit_valid;
    ctxt_t                    commit_ctxt;
    addr_t                    commit_addr;
    size_t                    commit_size;

    logic                     mem_wr_en;
    ctxt_t                    mem_wr_ctxt;
    addr_t                    mem_wr_addr;
    logic [`PKT_DATA_WID-1:0] mem_wr_data;

    packet_enqueue i_packet_enqueue (
        .clk           (clk),
        .srst          (srst),
        .wr_ctxt       (wr_ctxt),
        .commit_valid  (commit_valid),
        .commit_ctxt   (commit_ctxt),
        .commit_addr   (commit_addr),
        .commit_size   (commit_size),
        .rd_desc_valid (rd_desc_valid),
        .rd_desc_ctxt  (rd_desc_ctxt),
        .rd_desc_size  (rd_desc_size),
        .nxt_addr      (nxt_addr),
        .nxt_headroom  (nxt_headroom),
        .wr_desc_valid (wr_desc_valid),
        .wr_desc_ctxt  (wr_desc_ctxt),
        .wr_desc_addr  (wr_desc_addr),
        .wr_desc_size  (wr_desc_size)
    );

    packet_write i_packet_write (
        .clk           (clk),
        .srst          (srst),
        .mem_init_done (mem_init_done),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_eop        (in_eop),
        .in_mty        (in_mty),
        .in_err        (in_err),
        .ctxt_sel      (ctxt_sel),
        .in_ready      (in_ready),
        .wr_ctxt       (wr_ctxt),
        .nxt_addr      (nxt_addr),
        .nxt_headroom  (nxt_headroom),
        .mem_wr_en     (mem_wr_en),
        .mem_wr_ctxt   (mem_wr_ctxt),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .commit_valid  (commit_valid),
        .commit_ctxt   (commit_ctxt),
        .commit_addr   (commit_addr),
        .commit_size   (commit_size),
        .evt_valid     (evt_valid),
        .evt_kind      (evt_kind),
        .evt_size      (evt_size)
    );

    packet_mem i_packet_mem (
        .clk           (clk),
        .srst          (srst),
        .mem_init_done (mem_init_done),
        .mem_wr_en     (mem_wr_en),
        .mem_wr_ctxt   (mem_wr_ctxt),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .rd_en         (rd_en),
        .rd_ctxt       (rd_ctxt),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

endmodule : packet_buffer_top

//--- verilog/packet_enqueue.sv
// ----------------------------------------
// Per-context circular buffer pointers,
// headroom and write descriptor output
// ----------------------------------------
`include "packet_params.svh"

module packet_enqueue
    import packet_pkg::*;
(
    input  logic  clk,
    input  logic  srst,

    // Context of the packet being written
    input  ctxt_t wr_ctxt,

    // Commit from the writer
    input  logic  commit_valid,
    input  ctxt_t commit_ctxt,
    input  addr_t commit_addr,
    input  size_t commit_size,

    // Read completion from downstream
    input  logic  rd_desc_valid,
    input  ctxt_t rd_desc_ctxt,
    input  size_t rd_desc_size,

    // Next address feed to the writer
    output addr_t nxt_addr,
    output size_t nxt_headroom,

    // Write descriptor
    output logic  wr_desc_valid,
    output ctxt_t wr_desc_ctxt,
    output addr_t wr_desc_addr,
    output size_t wr_desc_size
);

    // Extra bit tells a full region from an empty one
    localparam int PTR_WID   = `PKT_ADDR_WID + 1;
    localparam int DEPTH     = 2 ** `PKT_ADDR_WID;
    localparam int MAX_WORDS = (`PKT_MAX_BYTES + `PKT_DATA_BYTES - 1) / `PKT_DATA_BYTES;

    logic [PTR_WID-1:0] head_ptr   [`PKT_NUM_CTXT];
    logic [PTR_WID-1:0] tail_ptr   [`PKT_NUM_CTXT];
    logic [PTR_WID-1:0] used_words [`PKT_NUM_CTXT];
    logic [PTR_WID-1:0] free_words [`PKT_NUM_CTXT];
    size_t              headroom_q [`PKT_NUM_CTXT];

    logic [PTR_WID-1:0] commit_words;
    logic [PTR_WID-1:0] rd_words;

    // Byte size to whole words, rounded up
    function automatic logic [PTR_WID-1:0] size_to_words(input size_t size);
        logic [PTR_WID-1:0] bytes;
        bytes = PTR_WID'(size) + PTR_WID'(`PKT_DATA_BYTES - 1);
        return bytes / PTR_WID'(`PKT_DATA_BYTES);
    endfunction

    assign commit_words = size_to_words(commit_size);
    assign rd_words     = size_to_words(rd_desc_size);

    // ----------------------------------------
    // Head and tail pointers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            for (int c = 0; c < `PKT_NUM_CTXT; c++) begin
                head_ptr[c] <= '0;
                tail_ptr[c] <= '0;
            end
        end else begin
            if (commit_valid) begin
                head_ptr[commit_ctxt] <= head_ptr[commit_ctxt] + commit_words;
            end
            if (rd_desc_valid) begin
                tail_ptr[rd_desc_ctxt] <= tail_ptr[rd_desc_ctxt] + rd_words;
            end
        end
    end

    // ----------------------------------------
    // Occupancy and headroom
    // ----------------------------------------
    always_comb begin
        for (int c = 0; c < `PKT_NUM_CTXT; c++) begin
            used_words[c] = head_ptr[c] - tail_ptr[c];
            free_words[c] = PTR_WID'(DEPTH) - used_words[c];
        end
    end

    // Capped at one max-size packet
    always_ff @(posedge clk) begin
        for (int c = 0; c < `PKT_NUM_CTXT; c++) begin
            if (srst) begin
                headroom_q[c] <= size_t'(`PKT_MAX_BYTES);
            end else if (free_words[c] >= PTR_WID'(MAX_WORDS)) begin
                headroom_q[c] <= size_t'(`PKT_MAX_BYTES);
            end else begin
                headroom_q[c] <= size_t'(free_words[c] * `PKT_DATA_BYTES);
            end
        end
    end

    // ----------------------------------------
    // Writer feed and descriptor
    // ----------------------------------------
    assign nxt_addr     = addr_t'(head_ptr[wr_ctxt]);
    assign nxt_headroom = headroom_q[wr_ctxt];

    // Descriptor goes out with the commit that moves the head
    assign wr_desc_valid = commit_valid;
    assign wr_desc_ctxt  = commit_ctxt;
    assign wr_desc_addr  = commit_addr;
    assign wr_desc_size  = commit_size;

endmodule : packet_enqueue

//--- verilog/packet_mem.sv
// ----------------------------------------
// Shared packet word memory, self-clearing
// ----------------------------------------
`include "packet_params.svh"

module packet_mem
    import packet_pkg::*;
(
    input  logic                     clk,
    input  logic                     srst,
    output logic                     mem_init_done,

    input  logic                     mem_wr_en,
    input  ctxt_t                    mem_wr_ctxt,
    input  addr_t                    mem_wr_addr,
    input  logic [`PKT_DATA_WID-1:0] mem_wr_data,

    input  logic                     rd_en,
    input  ctxt_t                    rd_ctxt,
    input  addr_t                    rd_addr,
    output logic [`PKT_DATA_WID-1:0] rd_data
);

    // Context picks the region, upper address bits
    localparam int MEM_ADDR_WID = CTXT_WID + `PKT_ADDR_WID;
    localparam int DEPTH        = 2 ** MEM_ADDR_WID;

    logic [`PKT_DATA_WID-1:0] mem [DEPTH];
    logic [MEM_ADDR_WID-1:0]  init_cnt_q;
    logic                     init_done_q;

    // Init sweep, one word per cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            init_cnt_q  <= '0;
            init_done_q <= 1'b0;
        end else if (!init_done_q) begin
            init_cnt_q <= init_cnt_q + 1'b1;
            if (init_cnt_q == '1) begin
                init_done_q <= 1'b1;
            end
        end
    end

    assign mem_init_done = init_done_q;

    always_ff @(posedge clk) begin
        if (!init_done_q) begin
            mem[init_cnt_q] <= '0;
        end else if (mem_wr_en) begin
            mem[{mem_wr_ctxt, mem_wr_addr}] <= mem_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[{rd_ctxt, rd_addr}];
        end
    end

endmodule : packet_mem

//--- verilog/packet_params.svh
// ----------------------------------------
// Packet buffer sizing constants
// ----------------------------------------
`ifndef PACKET_PARAMS_SVH
`define PACKET_PARAMS_SVH

// Stream word
`define PKT_DATA_BYTES 4
`define PKT_DATA_WID (`PKT_DATA_BYTES * 8)

// Word address inside one context region (128 words)
`define PKT_ADDR_WID 7

// Number of buffer contexts
`define PKT_NUM_CTXT 2

// Accepted packet size range, in bytes
`define PKT_MIN_BYTES 8
`define PKT_MAX_BYTES 64

`endif

//--- verilog/packet_pkg.sv
// ----------------------------------------
// Packet buffer shared types
// ----------------------------------------
`include "packet_params.svh"

package packet_pkg;

    localparam int CTXT_WID = (`PKT_NUM_CTXT > 1) ? $clog2(`PKT_NUM_CTXT) : 1;

    // One word past the max size, so an oversize count stays visible
    localparam int SIZE_WID = $clog2(`PKT_MAX_BYTES + `PKT_DATA_BYTES + 1);

    typedef logic [CTXT_WID-1:0]      ctxt_t;
    typedef logic [`PKT_ADDR_WID-1:0] addr_t;
    typedef logic [SIZE_WID-1:0]      size_t;

    // Empty bytes in the last word of a packet
    typedef logic [1:0] mty_t;

    // Per-packet outcome
    typedef enum logic [2:0] {
        EVT_OK         = 3'd0,
        EVT_DROP_ERR   = 3'd1,
        EVT_DROP_SHORT = 3'd2,
        EVT_DROP_LONG  = 3'd3,
        EVT_DROP_FULL  = 3'd4
    } event_kind_t;

endpackage : packet_pkg

//--- verilog/packet_write.sv
// ----------------------------------------
// Packet writer: stores words, sizes the
// packet, then commits or drops it
// ----------------------------------------
`include "packet_params.svh"

module packet_write
    import packet_pkg::*;
(
    input  logic                     clk,
    input  logic                     srst,
    input  logic                     mem_init_done,

    // Input stream
    input  logic                     in_valid,
    input  logic [`PKT_DATA_WID-1:0] in_data,
    input  logic                     in_eop,
    input  mty_t                     in_mty,
    input  logic                     in_err,
    input  ctxt_t                    ctxt_sel,
    output logic                     in_ready,
    output ctxt_t                    wr_ctxt,

    // From enqueue, for wr_ctxt
    input  addr_t                    nxt_addr,
    input  size_t                    nxt_headroom,

    // Memory write
    output logic                     mem_wr_en,
    output ctxt_t                    mem_wr_ctxt,
    output addr_t                    mem_wr_addr,
    output logic [`PKT_DATA_WID-1:0] mem_wr_data,

    // Commit to enqueue
    output logic                     commit_valid,
    output ctxt_t                    commit_ctxt,
    output addr_t                    commit_addr,
    output size_t                    commit_size,

    // Per-packet event
    output logic                     evt_valid,
    output event_kind_t              evt_kind,
    output size_t                    evt_size
);

    localparam int WORD_BYTES = `PKT_DATA_BYTES;
    localparam int MAX_WORDS  = (`PKT_MAX_BYTES + WORD_BYTES - 1) / WORD_BYTES;
    localparam int SAT_BYTES  = `PKT_MAX_BYTES + WORD_BYTES;

    typedef enum logic [1:0] {
        ST_SOP,
        ST_BODY,
        ST_COMMIT
    } state_t;

    state_t state_q;

    // Packet state latched at sop
    ctxt_t ctxt_q;
    addr_t base_q;
    size_t headroom_q;
    logic  err_q;
    size_t bytes_q;

    logic        sop;
    logic        accept;
    ctxt_t       cur_ctxt;
    addr_t       cur_base;
    size_t       cur_headroom;
    logic        cur_err;
    size_t       prev_bytes;
    size_t       cur_bytes;
    size_t       cur_off;
    logic        wr_ok;
    size_t       pkt_size;
    event_kind_t kind;

    // ----------------------------------------
    // Handshake and current-word view
    // ----------------------------------------
    assign sop      = (state_q == ST_SOP);
    assign in_ready = mem_init_done && (state_q != ST_COMMIT);
    assign accept   = in_valid && in_ready;

    // At sop everything comes straight from the inputs
    assign cur_ctxt     = sop ? ctxt_sel : ctxt_q;
    assign cur_base     = sop ? nxt_addr : base_q;
    assign cur_headroom = sop ? nxt_headroom : headroom_q;
    assign cur_err      = (sop ? 1'b0 : err_q) | in_err;
    assign wr_ctxt      = cur_ctxt;

    // Byte count saturates one word past max
    assign prev_bytes = sop ? '0 : bytes_q;
    assign cur_bytes  = (prev_bytes >= size_t'(SAT_BYTES - WORD_BYTES)) ?
                        size_t'(SAT_BYTES) : prev_bytes + size_t'(WORD_BYTES);
    assign cur_off    = prev_bytes / size_t'(WORD_BYTES);
    assign wr_ok      = (cur_off < size_t'(MAX_WORDS));
    assign pkt_size   = cur_bytes - size_t'(in_mty);

    // Drop priority: err, long, short, full
    always_comb begin
        if (cur_err) begin
            kind = EVT_DROP_ERR;
        end else if (pkt_size > size_t'(`PKT_MAX_BYTES)) begin
            kind = EVT_DROP_LONG;
        end else if (pkt_size < size_t'(`PKT_MIN_BYTES)) begin
            kind = EVT_DROP_SHORT;
        end else if (pkt_size > cur_headroom) begin
            kind = EVT_DROP_FULL;
        end else begin
            kind = EVT_OK;
        end
    end

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state_q <= ST_SOP;
        end else begin
            case (state_q)
                ST_SOP, ST_BODY: begin
                    if (accept) begin
                        state_q <= in_eop ? ST_COMMIT : ST_BODY;
                    end
                end
                ST_COMMIT: state_q <= ST_SOP;
                default:   state_q <= ST_SOP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ctxt_q     <= cur_ctxt;
            base_q     <= cur_base;
            headroom_q <= cur_headroom;
            err_q      <= cur_err;
            bytes_q    <= cur_bytes;
        end
    end

    // ----------------------------------------
    // Memory write
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            mem_wr_en <= 1'b0;
        end else begin
            mem_wr_en <= accept && wr_ok;
        end
    end

    // Region wrap comes from the address width
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_wr_ctxt <= cur_ctxt;
            mem_wr_addr <= cur_base + addr_t'(cur_off);
            mem_wr_data <= in_data;
        end
    end

    // ----------------------------------------
    // Commit and event strobes
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            evt_valid    <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            evt_valid    <= accept && in_eop;
            commit_valid <= accept && in_eop && (kind == EVT_OK);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && in_eop) begin
            evt_kind    <= kind;
            evt_size    <= pkt_size;
            commit_ctxt <= cur_ctxt;
            commit_addr <= cur_base;
            commit_size <= pkt_size;
        end
    end

endmodule : packet_write
